// File: ahbPkg.sv
// AHB-Lite shared definitions
// Bus widths, transfer enums and the request/response structs used by
// the decoder, the slaves and the response multiplexer
`default_nettype none

package ahbPkg;

  // Fixed bus widths
  localparam int AddrWidth = 32;
  localparam int DataWidth = 64;

  // Transfer type, HTRANS encoding
  typedef enum logic [1:0] {
    transIdle   = 2'b00,
    transBusy   = 2'b01,
    transNonseq = 2'b10,
    transSeq    = 2'b11
  } htransE;

  // Transfer size, HSIZE encoding up to a doubleword
  typedef enum logic [2:0] {
    sizeByte   = 3'b000,
    sizeHalf   = 3'b001,
    sizeWord   = 3'b010,
    sizeDouble = 3'b011
  } hsizeE;

  // Slave response
  typedef enum logic {
    respOkay  = 1'b0,
    respError = 1'b1
  } hrespE;

  // Default slave error sequence
  typedef enum logic [1:0] {
    dsIdle      = 2'b00,
    dsErrFirst  = 2'b01,
    dsErrSecond = 2'b10
  } dsStateE;

  // Address-phase signals from the master
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    htransE               trans;
    logic                 write;
    hsizeE                size;
    logic [2:0]           burst;
    logic [3:0]           prot;
    logic                 mastLock;
  } ahbReqS;

  // One slave's data-phase response
  typedef struct packed {
    logic                 readyOut;
    hrespE                resp;
    logic [DataWidth-1:0] rdata;
  } ahbRespS;

endpackage

`default_nettype wire

// File: ahbDecoder.sv
// AHB-Lite address decoder
// Compares HADDR with the top of the SRAM region and raises exactly one
// slave select during the address phase
`timescale 1ns/10ps
`default_nettype none

module ahbDecoder
  import ahbPkg::*;
#(
  parameter int MemBytes = 5120
)
(
  input  ahbReqS req,
  output logic   selMem,
  output logic   selDefault
);

  // First unmapped byte address
  localparam logic [AddrWidth-1:0] MemTop = AddrWidth'(MemBytes);

  // Region test by magnitude compare
  // Allows a boundary that is not a power of two, e.g. 0x1400
  logic inMem;

  always_comb
  begin
    inMem = (req.addr < MemTop);
  end

  // One-hot selects
  always_comb
  begin
    selMem     = inMem;
    selDefault = ~inMem;
  end

endmodule

`default_nettype wire

// File: ahbSramSlave.sv
// AHB-Lite zero-wait SRAM slave
// Doubleword-wide memory with byte-lane writes, registered address phase
// and combinational read data in the data phase
`timescale 1ns/10ps
`default_nettype none

module ahbSramSlave
  import ahbPkg::*;
#(
  parameter int MemBytes = 5120
)
(
  input  logic                 HCLK,
  input  logic                 HRESET,
  input  ahbReqS               req,
  input  logic                 sel,
  input  logic                 HREADY,
  input  logic [DataWidth-1:0] HWDATA,
  output ahbRespS              resp
);

  // Memory geometry
  localparam int Lanes   = DataWidth / 8;
  localparam int OffBits = $clog2(Lanes);
  localparam int Words   = MemBytes / Lanes;
  localparam int IdxBits = $clog2(Words);

  // Storage, no reset
  logic [DataWidth-1:0] mem [Words];

  // Data-phase copy of the address phase
  logic               activeQ;
  logic               writeQ;
  logic [IdxBits-1:0] wordIdxQ;
  logic [OffBits-1:0] byteOffQ;
  hsizeE              sizeQ;

  logic               addrValid;
  logic               memWrEn;
  logic [Lanes-1:0]   wrMask;

  // Lanes touched by a transfer of this size at this offset
  function automatic logic [Lanes-1:0] laneMask(input hsizeE size,
                                                input logic [OffBits-1:0] offset);
    case (size)
      sizeByte: laneMask = Lanes'(8'h01) << offset;
      sizeHalf: laneMask = Lanes'(8'h03) << offset;
      sizeWord: laneMask = Lanes'(8'h0F) << offset;
      default:  laneMask = '1;
    endcase
  endfunction

  // Accepted NONSEQ or SEQ transfer aimed at this slave
  always_comb
  begin
    addrValid = HREADY && sel &&
                ((req.trans == transNonseq) || (req.trans == transSeq));
  end

  // Active flag follows every accepted address phase
  always_ff @(posedge HCLK, negedge HRESET)
  begin
    if (!HRESET)
    begin
      activeQ <= 1'b0;
    end
    else if (HREADY)
    begin
      activeQ <= addrValid;
    end
  end

  // Payload of the address phase, only loaded for our own transfers
  always_ff @(posedge HCLK)
  begin
    if (addrValid)
    begin
      writeQ   <= req.write;
      wordIdxQ <= req.addr[OffBits +: IdxBits];
      byteOffQ <= req.addr[OffBits-1:0];
      sizeQ    <= req.size;
    end
  end

  // Write lands at the end of its data phase
  always_comb
  begin
    memWrEn = activeQ && writeQ && HREADY;
    wrMask  = laneMask(sizeQ, byteOffQ);
  end

  always_ff @(posedge HCLK)
  begin
    if (memWrEn)
    begin
      for (int lane = 0; lane < Lanes; lane++)
      begin
        // Only the lanes picked by size and offset
        if (wrMask[lane])
          mem[wordIdxQ][lane*8 +: 8] <= HWDATA[lane*8 +: 8];
      end
    end
  end

  // Response, always ready and OKAY
  always_comb
  begin
    resp.readyOut = 1'b1;
    resp.resp     = respOkay;
    // Whole doubleword on a read, zero otherwise
    resp.rdata    = (activeQ && !writeQ) ? mem[wordIdxQ] : '0;
  end

endmodule

`default_nettype wire

// File: ahbDefaultSlave.sv
// AHB-Lite default slave for the unmapped address space
// Answers NONSEQ and SEQ with the two-cycle ERROR response, IDLE and BUSY
// with a zero-wait OKAY
`timescale 1ns/10ps
`default_nettype none

module ahbDefaultSlave
  import ahbPkg::*;
(
  input  logic    HCLK,
  input  logic    HRESET,
  input  ahbReqS  req,
  input  logic    sel,
  input  logic    HREADY,
  output ahbRespS resp
);

  dsStateE state;
  dsStateE stateNext;
  logic    addrValid;

  // Accepted active transfer to the unmapped space
  always_comb
  begin
    addrValid = HREADY && sel &&
                ((req.trans == transNonseq) || (req.trans == transSeq));
  end

  // Error sequence FSM
  always_comb
  begin
    stateNext = state;
    case (state)
      dsIdle:
        if (addrValid)
          stateNext = dsErrFirst;
      dsErrFirst:
        stateNext = dsErrSecond;
      dsErrSecond:
        // Back-to-back errors restart the sequence
        stateNext = addrValid ? dsErrFirst : dsIdle;
      default:
        stateNext = dsIdle;
    endcase
  end

  always_ff @(posedge HCLK, negedge HRESET)
  begin
    if (!HRESET)
      state <= dsIdle;
    else
      state <= stateNext;
  end

  // Response decoded from state
  always_comb
  begin
    resp.readyOut = (state != dsErrFirst);
    resp.resp     = (state == dsIdle) ? respOkay : respError;
    resp.rdata    = '0;
  end

endmodule

`default_nettype wire

// File: ahbResponseMux.sv
// AHB-Lite response multiplexer
// Remembers which slave owns the current data phase and forwards
// that slave's read data, ready and response to the master
`timescale 1ns/10ps
`default_nettype none

module ahbResponseMux
  import ahbPkg::*;
(
  input  logic                 HCLK,
  input  logic                 HRESET,
  input  logic                 selMem,
  input  ahbRespS              memResp,
  input  ahbRespS              defResp,
  output logic [DataWidth-1:0] HRDATA,
  output logic                 HREADYOUT,
  output hrespE                HRESP
);

  // Data-phase owner, high for the SRAM slave
  logic    dataSelMem;
  ahbRespS selResp;

  // Advances only when the current data phase completes
  // Reset points at the default slave, idle there is ready and OKAY
  always_ff @(posedge HCLK, negedge HRESET)
  begin
    if (!HRESET)
      dataSelMem <= 1'b0;
    else if (HREADYOUT)
      dataSelMem <= selMem;
  end

  // Pick the owning slave's response
  always_comb
  begin
    selResp   = dataSelMem ? memResp : defResp;
    HRDATA    = selResp.rdata;
    HREADYOUT = selResp.readyOut;
    HRESP     = selResp.resp;
  end

endmodule

`default_nettype wire

// File: ahbSubsystem.sv
// AHB-Lite slave subsystem top level
// Packs the master signals into a request, decodes it to the SRAM or the
// default slave and returns the selected response with HREADY feedback
`timescale 1ns/10ps
`default_nettype none

module ahbSubsystem
  import ahbPkg::*;
#(
  parameter int MemBytes = 5120
)
(
  input  logic                 HCLK,
  input  logic                 HRESET,
  input  logic [AddrWidth-1:0] HADDR,
  input  htransE               HTRANS,
  input  logic                 HWRITE,
  input  hsizeE                HSIZE,
  input  logic [2:0]           HBURST,
  input  logic [3:0]           HPROT,
  input  logic                 HMASTLOCK,
  input  logic [DataWidth-1:0] HWDATA,
  output logic [DataWidth-1:0] HRDATA,
  output logic                 HREADYOUT,
  output hrespE                HRESP
);

  ahbReqS  req;
  ahbRespS memResp;
  ahbRespS defResp;
  logic    selMem;
  logic    selDefault;

  // Master address phase as one struct
  assign req = '{addr: HADDR, trans: HTRANS, write: HWRITE, size: HSIZE,
                 burst: HBURST, prot: HPROT, mastLock: HMASTLOCK};

  ahbDecoder #(.MemBytes(MemBytes)) decoder (
    .req        (req),
    .selMem     (selMem),
    .selDefault (selDefault)
  );

  // HREADYOUT doubles as the global HREADY
  ahbSramSlave #(.MemBytes(MemBytes)) sram (
    .HCLK   (HCLK),
    .HRESET (HRESET),
    .req    (req),
    .sel    (selMem),
    .HREADY (HREADYOUT),
    .HWDATA (HWDATA),
    .resp   (memResp)
  );

  ahbDefaultSlave defSlave (
    .HCLK   (HCLK),
    .HRESET (HRESET),
    .req    (req),
    .sel    (selDefault),
    .HREADY (HREADYOUT),
    .resp   (defResp)
  );

  ahbResponseMux respMux (
    .HCLK      (HCLK),
    .HRESET    (HRESET),
    .selMem    (selMem),
    .memResp   (memResp),
    .defResp   (defResp),
    .HRDATA    (HRDATA),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP)
  );

endmodule

`default_nettype wire

// File: ahbSubsystemAssert.sv
// AHB-Lite default slave protocol checks
// Concurrent assertions on the two-cycle ERROR response, bound into
// every instance of the default slave
`timescale 1ns/10ps
`default_nettype none

module ahbDefaultSlaveChecks
  import ahbPkg::*;
(
  input logic    HCLK,
  input logic    HRESET,
  input ahbRespS resp
);

  // Failures seen so far, read by the testbench summary
  int failCount = 0;

  // First ERROR cycle waits, the second one completes
  errorPair: assert property (@(posedge HCLK) disable iff (!HRESET)
    (!resp.readyOut && resp.resp == respError) |=>
    (resp.readyOut && resp.resp == respError))
  else
  begin
    $error("ERROR wait cycle not followed by ERROR ready cycle");
    failCount++;
  end

  // Wait states only come with ERROR
  noOkayWait: assert property (@(posedge HCLK) disable iff (!HRESET)
    !(!resp.readyOut && resp.resp == respOkay))
  else
  begin
    $error("Default slave inserted a wait state with OKAY");
    failCount++;
  end

  // No read data from unmapped space
  zeroData: assert property (@(posedge HCLK) disable iff (!HRESET)
    resp.rdata == '0)
  else
  begin
    $error("Default slave drove nonzero read data");
    failCount++;
  end

endmodule

bind ahbDefaultSlave ahbDefaultSlaveChecks defAssert (
  .HCLK   (HCLK),
  .HRESET (HRESET),
  .resp   (resp)
);

`default_nettype wire

// File: ahbSubsystemTb.sv
// AHB-Lite subsystem testbench
// Pipelined master model with random traffic, shadow memory reference
// and a compare process on every completed data phase
`timescale 1ns/10ps
`default_nettype none

module ahbSubsystemTb
  import ahbPkg::*;
;

  localparam int MemBytes = 5120;

  logic                 HCLK;
  logic                 HRESET;
  logic [AddrWidth-1:0] HADDR;
  htransE               HTRANS;
  logic                 HWRITE;
  hsizeE                HSIZE;
  logic [2:0]           HBURST;
  logic [3:0]           HPROT;
  logic                 HMASTLOCK;
  logic [DataWidth-1:0] HWDATA;
  logic [DataWidth-1:0] HRDATA;
  logic                 HREADYOUT;
  hrespE                HRESP;

  // Expected memory contents by byte
  logic [7:0]  shadow [MemBytes];
  logic [31:0] lfsrState   = 32'h894d85dd;
  int          errorCount  = 0;
  int          checkCount  = 0;
  int          issuedCount = 0;
  int          cycleCount  = 0;

  // Transfer currently in its data phase
  logic        dpValid = 1'b0;
  logic        dpActive;
  logic        dpMapped;
  logic        dpWrite;
  logic [31:0] dpAddr;
  int          dpCycle;

  ahbSubsystem #(.MemBytes(MemBytes)) dut (
    .HCLK      (HCLK),
    .HRESET    (HRESET),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HBURST    (HBURST),
    .HPROT     (HPROT),
    .HMASTLOCK (HMASTLOCK),
    .HWDATA    (HWDATA),
    .HRDATA    (HRDATA),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #50 HCLK = ~HCLK;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [63:0] randBits(input int n);
    logic [63:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      bits = {bits[62:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
    end
    randBits = bits;
  endfunction

  // Merges a write into the shadow by lane and returns the whole doubleword
  function automatic logic [63:0] refAccess(input logic write, input logic [31:0] addr,
                                            input hsizeE size, input logic [63:0] wdata);
    logic [31:0] base;
    logic [63:0] dword;
    int          nBytes;
    base   = {addr[31:3], 3'b000};
    nBytes = 1 << int'(size);
    if (write)
    begin
      // Lane follows the low address bits
      for (int i = 0; i < nBytes; i++)
        shadow[addr + i] = wdata[(addr[2:0] + i) * 8 +: 8];
    end
    for (int i = 0; i < 8; i++)
      dword[i*8 +: 8] = shadow[base + i];
    refAccess = dword;
  endfunction

  task automatic compareValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Fail at %0t: %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // One pipelined transfer entered and left on a falling edge
  task automatic issue(input htransE trans, input logic write, input logic [31:0] addr,
                       input hsizeE size, input logic [63:0] wdata);
    HADDR     = addr;
    HTRANS    = trans;
    HWRITE    = write;
    HSIZE     = size;
    HBURST    = 3'b000;
    HPROT     = 4'h3;
    HMASTLOCK = 1'b0;
    issuedCount++;
    // Hold the address phase until the bus is ready
    while (HREADYOUT !== 1'b1)
      @(negedge HCLK);
    @(negedge HCLK);
    // Accepted and now in its data phase
    HWDATA   = wdata;
    dpActive = (trans == transNonseq) || (trans == transSeq);
    dpMapped = addr < MemBytes;
    dpWrite  = write;
    dpAddr   = addr;
    dpCycle  = 0;
    dpValid  = 1'b1;
    if (dpActive && dpMapped && write)
      void'(refAccess(1'b1, addr, size, wdata));
  endtask

  task automatic writeMem(input logic [31:0] addr, input hsizeE size, input logic [63:0] data);
    issue(transNonseq, 1'b1, addr, size, data);
  endtask

  task automatic readMem(input logic [31:0] addr);
    issue(transNonseq, 1'b0, addr, sizeDouble, '0);
  endtask

  // Error response must overlap an IDLE address phase
  task automatic unmappedAccess(input htransE trans, input logic write,
                                input logic [31:0] addr);
    issue(trans, write, addr, sizeDouble, randBits(64));
    issue(transIdle, 1'b0, addr, sizeByte, '0);
  endtask

  task automatic finishRun;
    errorCount += dut.defSlave.defAssert.failCount;
    $display("Checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  endtask

  // Checks each data-phase cycle against the bus rules and the shadow
  always @(posedge HCLK)
  begin : compare
    logic  expReady;
    hrespE expResp;
    if (HRESET && dpValid)
    begin
      // Unmapped active transfer waits one cycle
      expReady = !(dpActive && !dpMapped) || (dpCycle != 0);
      expResp  = (dpActive && !dpMapped) ? respError : respOkay;
      compareValue("HREADYOUT", 64'(expReady), 64'(HREADYOUT));
      compareValue("HRESP", 64'(expResp), 64'(HRESP));
      if (dpActive && dpMapped && !dpWrite)
        compareValue("HRDATA", refAccess(1'b0, dpAddr, sizeDouble, '0), HRDATA);
      if (HREADYOUT)
        dpValid = 1'b0;
      else
        dpCycle++;
    end
  end

  // Limit grows with every issued transfer
  always @(posedge HCLK)
  begin
    cycleCount++;
    if (cycleCount > 16 + 3 * issuedCount + 50)
    begin
      $display("Timeout: the bus stopped completing transfers after %0d cycles", cycleCount);
      errorCount++;
      finishRun();
    end
  end

  initial
  begin : main
    logic [31:0] addrList [16];
    logic [31:0] addr;
    logic [31:0] base;
    HRESET    = 1'b0;
    HADDR     = '0;
    HTRANS    = transIdle;
    HWRITE    = 1'b0;
    HSIZE     = sizeByte;
    HBURST    = '0;
    HPROT     = '0;
    HMASTLOCK = 1'b0;
    HWDATA    = '0;
    for (int a = 0; a < MemBytes; a++)
      shadow[a] = 8'h00;

    // Idle response while in reset
    repeat (16)
    begin
      @(negedge HCLK);
      compareValue("HREADYOUT", 64'(1'b1), 64'(HREADYOUT));
      compareValue("HRESP", 64'(respOkay), 64'(HRESP));
      compareValue("HRDATA", '0, HRDATA);
    end
    HRESET = 1'b1;
    issue(transIdle, 1'b0, '0, sizeDouble, '0);

    // Random doublewords with some read straight after the write
    for (int i = 0; i < 16; i++)
    begin
      addrList[i] = 32'((randBits(10) % (MemBytes / 8)) * 8);
      writeMem(addrList[i], sizeDouble, randBits(64));
      if (i % 4 == 3)
        readMem(addrList[i]);
    end
    for (int i = 0; i < 16; i++)
      readMem(addrList[i]);

    // Byte, halfword and word lanes at every aligned offset
    base = 32'h0100;
    writeMem(base, sizeDouble, randBits(64));
    for (int s = 0; s < 3; s++)
    begin
      for (int off = 0; off < 8; off += (1 << s))
        writeMem(base + off, hsizeE'(s), randBits(64));
      readMem(base);
    end

    // Active transfers to unmapped space
    // Random unmapped address whose low bits alias a written doubleword
    addr = 32'h8000_0000 | (32'(randBits(16)) << 13) | addrList[0][12:0];
    unmappedAccess(transNonseq, 1'b1, MemBytes);
    unmappedAccess(transNonseq, 1'b0, 32'hFFFF_FFF8);
    unmappedAccess(transNonseq, 1'b1, addr);
    unmappedAccess(transSeq, 1'b0, addr);
    readMem(addrList[0]);
    readMem(base);

    // IDLE and BUSY there complete at once
    issue(transIdle, 1'b1, MemBytes, sizeWord, '0);
    issue(transBusy, 1'b0, 32'hFFFF_FFF8, sizeDouble, '0);
    issue(transIdle, 1'b0, addr, sizeByte, '0);

    // Last doubleword is memory and the next byte is not
    writeMem(MemBytes - 8, sizeDouble, randBits(64));
    readMem(MemBytes - 8);
    unmappedAccess(transNonseq, 1'b0, MemBytes);
    readMem(MemBytes - 8);

    issue(transIdle, 1'b0, '0, sizeByte, '0);
    repeat (2) @(negedge HCLK);
    finishRun();
  end

endmodule

`default_nettype wire

// File: flist.f
ahbPkg.sv
ahbDecoder.sv
ahbSramSlave.sv
ahbDefaultSlave.sv
ahbResponseMux.sv
ahbSubsystem.sv
ahbSubsystemAssert.sv
ahbSubsystemTb.sv

// File: Bender.yml
package:
  name: ahb_subsystem

sources:
  - ahbPkg.sv
  - ahbDecoder.sv
  - ahbSramSlave.sv
  - ahbDefaultSlave.sv
  - ahbResponseMux.sv
  - ahbSubsystem.sv
  - target: test
    files:
      - ahbSubsystemAssert.sv
      - ahbSubsystemTb.sv
